// ==== compile.f ====
+incdir+.
link_pkg.sv
link_train.sv
link_tx.sv
link_rx.sv
link_apb_regs.sv
link_top.sv
tb_link.sv

// ==== link_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "link_defines.svh"

module link_apb_regs (
  input  wire                         clk,
  input  wire                         rst,
  input  wire  [7:0]                  paddr,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire  [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  wire link_pkg::link_status_t status,
  input  wire link_pkg::link_word_t   rx_word,
  input  wire                         rx_done,
  input  wire                         tx_ready,
  input  wire                         tx_done,
  output link_pkg::link_word_t        tx_word,
  output logic                        tx_valid,
  output logic                        master_sel
);
  import link_pkg::*;

  link_word_t   rx_buf;
  link_status_t stat_rd;
  logic         rx_full, rx_overrun, tx_inflight;
  logic         access, wr, rd, addr_ok, tx_hi_err;

  assign pready = 1'b1;
  assign access = psel && penable;
  assign wr     = access && pwrite && !pslverr;
  assign rd     = access && !pwrite && !pslverr;

  // Send refused while one is pending, link down, or kind empty
  assign tx_hi_err = pwrite && (paddr == `LINK_REG_TX_HI) &&
                     (tx_valid || tx_inflight || !status.running || pwdata[9:8] == 2'b00);
  assign pslverr   = access && (!addr_ok || tx_hi_err);

  assign stat_rd = '{running:    status.running,
                     tx_busy:    status.tx_busy || tx_valid || tx_inflight,
                     rx_valid:   rx_full,
                     rx_overrun: rx_overrun};

  always_comb begin
    prdata  = '0;
    addr_ok = 1'b1;
    case (paddr)
      `LINK_REG_CTRL:   prdata[0]   = master_sel;
      `LINK_REG_STATUS: prdata[3:0] = stat_rd;
      `LINK_REG_TX_LO:  prdata      = tx_word.data[31:0];
      `LINK_REG_TX_HI:  prdata      = {22'd0, tx_word.kind, 2'b00, tx_word.data[37:32]};
      `LINK_REG_RX_LO:  prdata      = rx_buf.data[31:0];
      `LINK_REG_RX_HI:  prdata      = {22'd0, rx_buf.kind, 2'b00, rx_buf.data[37:32]};
      default:          addr_ok     = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      master_sel  <= 1'b0;
      tx_valid    <= 1'b0;
      tx_inflight <= 1'b0;
      rx_full     <= 1'b0;
      rx_overrun  <= 1'b0;
    end else begin
      if (tx_valid && tx_ready) begin
        tx_valid    <= 1'b0;
        tx_inflight <= 1'b1;
      end else if (tx_done) begin
        tx_inflight <= 1'b0;
      end
      if (wr && paddr == `LINK_REG_TX_HI) tx_valid <= 1'b1;
      if (wr && paddr == `LINK_REG_CTRL) begin
        master_sel <= pwdata[0];
        if (pwdata[1]) rx_overrun <= 1'b0;
      end
      if (rd && paddr == `LINK_REG_RX_HI) rx_full <= 1'b0;
      if (rx_done) begin
        if (rx_full) rx_overrun <= 1'b1;  // New word dropped
        else rx_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr && paddr == `LINK_REG_TX_LO) tx_word.data[31:0] <= pwdata;
    if (wr && paddr == `LINK_REG_TX_HI) begin
      tx_word.data[37:32] <= pwdata[5:0];
      tx_word.kind        <= link_kind_e'(pwdata[9:8]);
    end
    if (rx_done && !rx_full) rx_buf <= rx_word;
  end

  a_no_wait: assert property (@(posedge clk) disable iff (rst)
    psel && penable |-> pready);

endmodule

`default_nettype wire

// ==== link_defines.svh ====
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// Payload lengths in bits, all even
`define LINK_LEN_CMD   38
`define LINK_LEN_RXS   26
`define LINK_LEN_TXIQ  32

// Training pace, clocks per step
`define LINK_TRAIN_TICKS 32

// APB register map
`define LINK_REG_CTRL   8'h00
`define LINK_REG_STATUS 8'h04
`define LINK_REG_TX_LO  8'h08
`define LINK_REG_TX_HI  8'h0C
`define LINK_REG_RX_LO  8'h10
`define LINK_REG_RX_HI  8'h14

`endif

// ==== link_pkg.sv ====
`default_nettype none
`include "link_defines.svh"

package link_pkg;

  typedef enum logic [1:0] {
    KIND_NONE = 2'b00,
    KIND_CMD  = 2'b01,
    KIND_RXS  = 2'b10,
    KIND_TXIQ = 2'b11
  } link_kind_e;

  // Shared by the training FSM and the send control
  typedef enum logic [3:0] {
    IDLE, SYNC1, SYNC2, WORK,
    MLINK0, MLINK1, MLINK2, MLINK3,
    SLINK0, SLINK1, SLINK2, SLINK3
  } train_state_e;

  typedef struct packed {
    link_kind_e                 kind;
    logic [`LINK_LEN_CMD-1:0]   data;  // Right-aligned payload
  } link_word_t;

  typedef struct packed {
    logic running;
    logic tx_busy;
    logic rx_valid;
    logic rx_overrun;
  } link_status_t;

endpackage

`default_nettype wire

// ==== link_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "link_defines.svh"

module link_rx (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  running,
  input  wire  [1:0]           sym_sync,
  output link_pkg::link_word_t rx_word,
  output logic                 rx_done
);
  import link_pkg::*;

  logic       busy;
  logic [4:0] sym_cnt;
  logic       start;

  assign start = running && !busy && (sym_sync != 2'b00);  // Header seen

  always_ff @(posedge clk) begin
    if (rst || !running) begin
      busy    <= 1'b0;
      sym_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        case (link_kind_e'(sym_sync))
          KIND_RXS:  sym_cnt <= 5'(`LINK_LEN_RXS / 2 - 1);
          KIND_TXIQ: sym_cnt <= 5'(`LINK_LEN_TXIQ / 2 - 1);
          default:   sym_cnt <= 5'(`LINK_LEN_CMD / 2 - 1);
        endcase
      end else if (busy) begin
        sym_cnt <= sym_cnt - 5'd1;
        if (sym_cnt == '0) begin
          busy    <= 1'b0;
          rx_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rx_word.kind <= link_kind_e'(sym_sync);
      rx_word.data <= '0;
    end else if (busy) begin
      rx_word.data <= {rx_word.data[`LINK_LEN_CMD-3:0], sym_sync};  // In at the bottom
    end
  end

endmodule

`default_nettype wire

// ==== link_stimulus.txt ====
# test side op addr data expect; test in decimal, the rest hex
# write/rand expect pslverr, poll data is a mask, rand data is the kind, pin addr 0 linktx 1 clk_lock_req
1 uut  write 0C 00000100 1
1 uut  pin   00 00000000 0
1 uut  read  04 00000000 0
2 uut  write 00 00000001 0
2 uut  poll  04 00000008 8
2 peer poll  04 00000008 8
2 peer pin   01 00000000 0
2 uut  read  00 00000000 1
3 uut  write 08 89ABCDEF 0
3 uut  write 0C 0000012A 0
3 peer poll  04 00000002 2
3 peer read  10 00000000 89ABCDEF
3 peer read  14 00000000 0000012A
3 peer read  04 00000000 8
4 uut  rand  08 00000002 0
4 uut  write 0C 0000023F 0
4 peer poll  04 00000002 2
4 peer rchk  10 00000000 0
4 peer read  14 00000000 00000200
4 peer rand  08 00000003 0
4 peer write 0C 00000315 0
4 uut  poll  04 00000002 2
4 uut  rchk  10 00000000 0
4 uut  read  14 00000000 00000300
5 uut  write 08 11111111 0
5 uut  write 0C 00000105 0
5 uut  write 0C 00000106 1
5 uut  read  04 00000000 C
5 peer poll  04 00000002 2
5 uut  poll  04 00000004 0
5 peer read  10 00000000 11111111
5 peer read  14 00000000 00000105
5 peer read  04 00000000 8
6 uut  write 08 AAAA5555 0
6 uut  write 0C 00000101 0
6 peer poll  04 00000002 2
6 uut  poll  04 00000004 0
6 uut  write 08 0F0F0F0F 0
6 uut  write 0C 00000102 0
6 peer poll  04 00000001 1
6 peer read  04 00000000 B
6 peer read  10 00000000 AAAA5555
6 peer read  14 00000000 00000101
6 peer write 00 00000002 0
6 peer read  04 00000000 8

// ==== link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_top (
  input  wire         clk,
  input  wire         rst,
  input  wire  [7:0]  paddr,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  wire  [1:0]  linkrx,
  output logic [1:0]  linktx,
  input  wire         clk_lock_ack,
  output logic        clk_lock_req
);
  import link_pkg::*;

  link_word_t   tx_word, rx_word;
  link_status_t status;
  logic         tx_valid, tx_ready, tx_done, tx_active;
  logic         rx_done, running, master_sel;
  logic [1:0]   sym_sync, train_linktx, tx_linktx;

  assign tx_active = running && !tx_ready;
  // Receive flags are kept in the register block
  assign status = '{running: running, tx_busy: tx_active, rx_valid: 1'b0, rx_overrun: 1'b0};
  assign linktx = running ? tx_linktx : train_linktx;

  link_apb_regs u_regs (
    .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .status, .rx_word, .rx_done, .tx_ready, .tx_done, .tx_word, .tx_valid, .master_sel
  );

  link_train u_train (
    .clk, .rst, .linkrx, .master_sel, .clk_lock_ack, .tx_active, .sym_sync,
    .sym_stable   (),  // Steers training only
    .train_linktx, .running, .clk_lock_req
  );

  link_tx u_tx (
    .clk, .rst, .running, .tx_word, .tx_valid, .tx_ready, .tx_done, .tx_linktx
  );

  link_rx u_rx (
    .clk, .rst, .running, .sym_sync, .rx_word, .rx_done
  );

endmodule

`default_nettype wire

// ==== link_train.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "link_defines.svh"

module link_train (
  input  wire        clk,
  input  wire        rst,
  input  wire  [1:0] linkrx,
  input  wire        master_sel,
  input  wire        clk_lock_ack,
  input  wire        tx_active,
  output logic [1:0] sym_sync,
  output logic [1:0] sym_stable,
  output logic [1:0] train_linktx,
  output logic       running,
  output logic       clk_lock_req
);
  import link_pkg::*;

  localparam int TICK_W = $clog2(`LINK_TRAIN_TICKS);

  train_state_e      state;
  train_state_e      state_next;
  logic [1:0]        sync1;
  logic [1:0]        pattern;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick;
  logic              role_master;  // Role the link was trained in

  always_ff @(posedge clk) begin
    if (rst) begin
      sync1      <= 2'b00;
      sym_sync   <= 2'b00;
      sym_stable <= 2'b00;
    end else begin
      sync1    <= linkrx;
      sym_sync <= sync1;
      if (sym_sync == sync1) sym_stable <= sym_sync;  // Two samples agree
    end
  end

  assign tick = (tick_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst || running || tick) tick_cnt <= TICK_W'(`LINK_TRAIN_TICKS - 1);
    else tick_cnt <= tick_cnt - 1'b1;
  end

  assign running = !(state inside {MLINK0, MLINK1, MLINK2, MLINK3,
                                   SLINK0, SLINK1, SLINK2, SLINK3});
  assign clk_lock_req = (state == SLINK3);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // Role change retrains, but never mid-frame
        if ((master_sel != role_master) && !tx_active)
          state_next = master_sel ? MLINK0 : SLINK0;
      end
      MLINK0: if (sym_stable == 2'b01 && tick) state_next = MLINK1;
      MLINK1: begin
        case (sym_stable)
          2'b01:   if (tick) state_next = MLINK0;
          2'b10:   if (tick) state_next = MLINK2;
          default: state_next = MLINK0;
        endcase
      end
      MLINK2: begin
        case (sym_stable)
          2'b10:   if (tick) state_next = MLINK0;
          2'b11:   if (tick) state_next = MLINK3;
          default: state_next = MLINK0;
        endcase
      end
      MLINK3: if (sym_stable == 2'b00) state_next = IDLE;  // Slave finished
      SLINK0: begin
        if (master_sel) state_next = MLINK0;
        else if (sym_stable == 2'b10) state_next = SLINK1;
      end
      SLINK1: begin
        if (master_sel) state_next = MLINK0;
        else if (sym_stable == 2'b01) state_next = SLINK2;
        else if (sym_stable != 2'b10) state_next = SLINK0;
      end
      SLINK2: begin
        if (master_sel) state_next = MLINK0;
        else if (sym_stable == 2'b11) state_next = SLINK3;
        else if (sym_stable != 2'b01) state_next = SLINK0;
      end
      SLINK3: begin
        if (master_sel) state_next = MLINK0;
        else if (clk_lock_ack && sym_stable == 2'b00) state_next = IDLE;
      end
      default: state_next = SLINK0;
    endcase
  end

  // Pattern follows the next state so the line is quiet on entry to IDLE
  always_comb begin
    case (state_next)
      MLINK0, SLINK2: pattern = 2'b10;
      MLINK1, SLINK1: pattern = 2'b01;
      MLINK2, SLINK3: pattern = 2'b11;
      default:        pattern = 2'b00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= SLINK0;
      train_linktx <= 2'b00;
      role_master  <= 1'b0;
    end else begin
      state        <= state_next;
      train_linktx <= pattern;
      if (state == MLINK3) role_master <= 1'b1;
      else if (state == SLINK3) role_master <= 1'b0;
    end
  end

  a_req_not_running: assert property (@(posedge clk) disable iff (rst)
    !(running && clk_lock_req));
  a_quiet_running: assert property (@(posedge clk) disable iff (rst)
    running |-> train_linktx == 2'b00);

endmodule

`default_nettype wire

// ==== link_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "link_defines.svh"

module link_tx (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       running,
  input  wire link_pkg::link_word_t tx_word,
  input  wire                       tx_valid,
  output logic                      tx_ready,
  output logic                      tx_done,
  output logic [1:0]                tx_linktx
);
  import link_pkg::*;

  train_state_e             state;
  logic [4:0]               sym_cnt;
  logic [`LINK_LEN_CMD-1:0] shreg;
  logic                     accept;

  assign tx_ready = running && (state == IDLE);
  assign accept   = tx_valid && tx_ready;
  assign tx_done  = (state == SYNC2);  // Second sync cycle

  always_ff @(posedge clk) begin
    if (rst || !running) begin
      state     <= IDLE;
      sym_cnt   <= '0;
      tx_linktx <= 2'b00;
    end else begin
      tx_linktx <= 2'b00;
      case (state)
        IDLE: begin
          if (accept) begin
            tx_linktx <= tx_word.kind;  // Header
            state     <= WORK;
            case (tx_word.kind)
              KIND_RXS:  sym_cnt <= 5'(`LINK_LEN_RXS / 2 - 1);
              KIND_TXIQ: sym_cnt <= 5'(`LINK_LEN_TXIQ / 2 - 1);
              default:   sym_cnt <= 5'(`LINK_LEN_CMD / 2 - 1);
            endcase
          end
        end
        WORK: begin
          tx_linktx <= shreg[`LINK_LEN_CMD-1 -: 2];  // MSB first
          sym_cnt   <= sym_cnt - 5'd1;
          if (sym_cnt == '0) state <= SYNC1;
        end
        SYNC1:   state <= SYNC2;
        default: state <= IDLE;
      endcase
    end
  end

  // Payload left-aligned so every kind leaves from the top
  always_ff @(posedge clk) begin
    if (accept) begin
      case (tx_word.kind)
        KIND_RXS:  shreg <= {tx_word.data[`LINK_LEN_RXS-1:0],
                             {(`LINK_LEN_CMD - `LINK_LEN_RXS){1'b0}}};
        KIND_TXIQ: shreg <= {tx_word.data[`LINK_LEN_TXIQ-1:0],
                             {(`LINK_LEN_CMD - `LINK_LEN_TXIQ){1'b0}}};
        default:   shreg <= tx_word.data;
      endcase
    end else if (state == WORK) begin
      shreg <= {shreg[`LINK_LEN_CMD-3:0], 2'b00};
    end
  end

  a_kind_set: assert property (@(posedge clk) disable iff (rst)
    accept |-> tx_word.kind != KIND_NONE);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module tb_link || exit 1
out=$(./obj_dir/Vtb_link)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb_link.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "link_defines.svh"

module tb_link;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_POLL, OP_RAND, OP_RCHK, OP_PIN, OP_BAD} op_e;

  typedef struct packed {
    logic [7:0]  test;
    logic        side;     // 0 uut, 1 peer
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_val;
  } stim_t;

  logic        clk = 1'b0;
  logic        rst;
  apb_req_t    req_u, req_p;
  logic        ack_u, ack_p;
  logic [31:0] prdata_u, prdata_p;
  logic        pready_u, pready_p, pslverr_u, pslverr_p;
  logic [1:0]  linktx_u, linktx_p;
  logic        lock_req_u, lock_req_p;

  stim_t       stim[$];
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  logic [31:0] rand_exp;
  logic        loaded = 1'b0;

  always #50 clk = ~clk;

  link_top uut (
    .clk, .rst, .paddr(req_u.paddr), .psel(req_u.psel), .penable(req_u.penable),
    .pwrite(req_u.pwrite), .pwdata(req_u.pwdata), .prdata(prdata_u), .pready(pready_u),
    .pslverr(pslverr_u), .linkrx(linktx_p), .linktx(linktx_u),
    .clk_lock_ack(ack_u), .clk_lock_req(lock_req_u)
  );

  link_top peer (
    .clk, .rst, .paddr(req_p.paddr), .psel(req_p.psel), .penable(req_p.penable),
    .pwrite(req_p.pwrite), .pwdata(req_p.pwdata), .prdata(prdata_p), .pready(pready_p),
    .pslverr(pslverr_p), .linkrx(linktx_u), .linktx(linktx_p),
    .clk_lock_ack(ack_p), .clk_lock_req(lock_req_p)
  );

  // Slave clock lock answers a few cycles after the request
  initial begin
    ack_p = 1'b0;
    wait (lock_req_p === 1'b1);
    repeat (3) @(posedge clk);
    ack_p <= 1'b1;
  end

  function automatic int kind_len(input logic [1:0] kind);
    case (kind)
      2'd1:    return 38;
      2'd2:    return 26;
      2'd3:    return 32;
      default: return 0;
    endcase
  endfunction

  function automatic logic [31:0] low_mask(input int len);
    logic [63:0] m;
    m = (64'd1 << len) - 64'd1;
    return m[31:0];  // Bits above 31 live in RX_HI
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input logic [7:0] num);
    if (test_errors == 0) $display("test %0d: pass", num);
    else $display("test %0d: fail, %0d errors", num, test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  task automatic drive_bus(input logic side, input apb_req_t r);
    if (side) req_p <= r;
    else req_u <= r;
  endtask

  task automatic apb_access(input logic side, input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    apb_req_t r;
    logic     rdy;
    r = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
    @(posedge clk);
    drive_bus(side, r);
    @(posedge clk);
    r.penable = 1'b1;
    drive_bus(side, r);
    @(negedge clk);  // Middle of the access phase
    rdata = side ? prdata_p : prdata_u;
    err   = side ? pslverr_p : pslverr_u;
    rdy   = side ? pready_p : pready_u;
    if (!rdy) report_error("pready was low in an access phase");
    @(posedge clk);
    drive_bus(side, '0);
  endtask

  task automatic load_stimulus();
    int          fd, n, tnum;
    string       line;
    logic [63:0] who, what;
    logic [31:0] addr, data, exp_val;
    stim_t       s;
    fd = $fopen("link_stimulus.txt", "r");
    if (fd == 0) begin
      report_error("could not open link_stimulus.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) n = $sscanf(line, "%d %s %s %h %h %h", tnum, who, what, addr, data, exp_val);
      if (n == 6) begin  // Comment and blank lines fall through
        s.test    = tnum[7:0];
        s.side    = (who == 64'("peer"));
        s.addr    = addr[7:0];
        s.data    = data;
        s.exp_val = exp_val;
        case (what)
          64'("write"): s.op = OP_WRITE;
          64'("read"):  s.op = OP_READ;
          64'("poll"):  s.op = OP_POLL;
          64'("rand"):  s.op = OP_RAND;
          64'("rchk"):  s.op = OP_RCHK;
          64'("pin"):   s.op = OP_PIN;
          default:      s.op = OP_BAD;
        endcase
        stim.push_back(s);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(input stim_t s);
    logic [31:0] rdata, rnd, got;
    logic        err;
    string       who;
    if (s.side) who = "peer";
    else who = "uut";
    case (s.op)
      OP_WRITE, OP_RAND: begin
        rnd = s.data;
        if (s.op == OP_RAND) begin
          rnd      = $urandom;
          rand_exp = rnd & low_mask(kind_len(s.data[1:0]));
        end
        apb_access(s.side, 1'b1, s.addr, rnd, rdata, err);
        if (err !== s.exp_val[0])
          report_error($sformatf("mismatch %s.pslverr write %h: got %h expected %h",
                                 who, s.addr, err, s.exp_val[0]));
      end
      OP_READ, OP_RCHK: begin
        apb_access(s.side, 1'b0, s.addr, 32'd0, rdata, err);
        got = (s.op == OP_RCHK) ? rand_exp : s.exp_val;
        if (err !== 1'b0) report_error($sformatf("%s refused a read of %h", who, s.addr));
        if (rdata !== got)
          report_error($sformatf("mismatch %s.prdata read %h: got %h expected %h",
                                 who, s.addr, rdata, got));
      end
      OP_POLL: begin
        do apb_access(s.side, 1'b0, s.addr, 32'd0, rdata, err);
        while ((rdata & s.data) !== s.exp_val);
      end
      OP_PIN: begin
        @(posedge clk);  // Header of the last write would be on the line here
        @(negedge clk);
        if (s.addr[0]) got = {31'd0, s.side ? lock_req_p : lock_req_u};
        else got = {30'd0, s.side ? linktx_p : linktx_u};
        if (got !== s.exp_val)
          report_error($sformatf("mismatch %s.%s: got %h expected %h", who,
                                 s.addr[0] ? "clk_lock_req" : "linktx", got, s.exp_val));
      end
      default: report_error("stimulus line has an unknown operation");
    endcase
  endtask

  initial begin
    int limit;
    wait (loaded);
    limit = stim.size() * 2000 + 64 * `LINK_TRAIN_TICKS;  // Training gets extra room
    repeat (limit) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    req_u     = '0;
    req_p     = '0;
    ack_u     = 1'b0;
    void'($urandom(71346));
    load_stimulus();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    foreach (stim[i]) begin
      if (i > 0 && stim[i].test != stim[i-1].test) finish_test(stim[i-1].test);
      run_op(stim[i]);
    end
    if (stim.size() > 0) finish_test(stim[stim.size()-1].test);
    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
